// File: verilog/predecode_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Pre-decode shared definitions.
// Widths, condition and prediction codes, instruction patterns and the
// packed bundles passed between fetch, pre-decode and decode.
////////////////////////////////////////////////////////////////////////////

package predecode_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // Widths and basic types.
        ////////////////////////////////////////////////////////////////////////////

        // Bit 34 flags a halfword (Thumb-derived) branch offset.
        localparam int INSTR_W = 35;
        localparam int ADDR_W  = 32;

        typedef logic [INSTR_W-1:0] instr_t;
        typedef logic [ADDR_W-1:0]  addr_t;

        // Two-bit saturating prediction state.
        typedef logic [1:0] taken_t;

        localparam taken_t TAKEN_ST  = 2'b11;
        localparam taken_t TAKEN_SNT = 2'b00;

        ////////////////////////////////////////////////////////////////////////////
        // Instruction fields and patterns.
        ////////////////////////////////////////////////////////////////////////////

        // Always condition.
        localparam logic [3:0] COND_AL = 4'b1110;

        // BX Rm, condition and Rm are don't care.
        localparam logic [31:0] BX_PATTERN = 32'b????_0001_0010_1111_1111_1111_0001_????;

        // Data processing MOV.
        localparam logic [3:0] MOV_OPCODE = 4'b1101;

        // Architectural register numbers.
        localparam logic [3:0] REG_LR = 4'd14;
        localparam logic [3:0] REG_PC = 4'd15;

        // Return address offset past the call.
        localparam addr_t LINK_STEP_ARM   = 32'd4;
        localparam addr_t LINK_STEP_THUMB = 32'd2;

        ////////////////////////////////////////////////////////////////////////////
        // Return address stack.
        ////////////////////////////////////////////////////////////////////////////

        localparam int RAS_DEPTH = 4;

        typedef logic [$clog2(RAS_DEPTH)-1:0] ras_ptr_t;

        ////////////////////////////////////////////////////////////////////////////
        // Bundles.
        ////////////////////////////////////////////////////////////////////////////

        // Stall and clear levels, highest priority first.
        typedef struct packed {
                logic clear_from_writeback;
                logic data_stall;
                logic clear_from_alu;
                logic stall_from_shifter;
                logic stall_from_issue;
        } pipe_ctrl_t;

        // Instruction bundle from fetch.
        typedef struct packed {
                taken_t taken;
                logic   force32;
                logic   und;
                logic   irq;
                logic   fiq;
                logic   abt;
                addr_t  pc;
                addr_t  pc_plus_8;
                instr_t instruction;
                logic   valid;
        } predecode_in_t;

        // Same layout toward decode; taken carries the updated prediction.
        typedef predecode_in_t predecode_out_t;

        // Fetch redirect.
        typedef struct packed {
                logic  clear;
                addr_t pc;
        } redirect_t;

endpackage

// File: verilog/return_stack.sv
////////////////////////////////////////////////////////////////////////////
// Return address stack.
// Small circular stack; overflow drops the oldest entry.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module return_stack
(
        // Clock and reset.
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Call pushes, return pops.
        input  logic                    i_push,
        input  logic                    i_pop,
        input  predecode_pkg::addr_t    i_push_addr,

        // Most recent return address.
        output predecode_pkg::addr_t    o_top
);

// Entry storage.
predecode_pkg::addr_t   entry_mem [predecode_pkg::RAS_DEPTH];

// Next free slot, wraps around.
predecode_pkg::ras_ptr_t ptr_ff;
predecode_pkg::ras_ptr_t top_ptr;

// Top is always the slot just below the pointer.
assign top_ptr = ptr_ff - predecode_pkg::ras_ptr_t'(1);
assign o_top   = entry_mem[top_ptr];

////////////////////////////////////////////////////////////////////////////
// Pointer.
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if ( i_reset )
                ptr_ff <= '0;
        else if ( i_push )
                ptr_ff <= ptr_ff + predecode_pkg::ras_ptr_t'(1);
        else if ( i_pop )
                ptr_ff <= top_ptr;
end

////////////////////////////////////////////////////////////////////////////
// Storage.
////////////////////////////////////////////////////////////////////////////

// A full stack simply overwrites.
always_ff @(posedge i_clk)
begin
        if ( i_push )
                entry_mem[ptr_ff] <= i_push_addr;
end

endmodule

// File: verilog/branch_predict.sv
////////////////////////////////////////////////////////////////////////////
// Static branch predictor.
// Spots B/BL and function returns, redirects fetch on a predicted-
// taken one and keeps the predicted PC and the return stack.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_predict
(
        // Clock and reset.
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Bundle from fetch.
        input  predecode_pkg::predecode_in_t    i_in,

        // CPU in Thumb state.
        input  logic                            i_thumb,

        // Stage advances this cycle.
        input  logic                            i_advance,

        // Fetch redirect, combinational.
        output predecode_pkg::redirect_t        o_redirect,

        // Updated prediction code, combinational.
        output predecode_pkg::taken_t           o_taken,

        // Predicted PC.
        output predecode_pkg::addr_t            o_ppc_ff
);

predecode_pkg::instr_t  instr;
logic                   cond_al;
logic                   is_branch;
logic                   is_bx_lr;
logic                   is_mov_pc_lr;
logic                   is_return;
logic                   predict_taken;
logic                   redirect;
logic                   push;
logic                   pop;
predecode_pkg::addr_t   offset;
predecode_pkg::addr_t   branch_target;
predecode_pkg::addr_t   target;
predecode_pkg::addr_t   link_addr;
predecode_pkg::addr_t   ras_top;

assign instr   = i_in.instruction;
assign cond_al = instr[31:28] == predecode_pkg::COND_AL;

////////////////////////////////////////////////////////////////////////////
// Recognition.
////////////////////////////////////////////////////////////////////////////

// B or BL, link in bit 24.
assign is_branch = i_in.valid && instr[27:25] == 3'b101;

// BX LR.
assign is_bx_lr = i_in.valid && (instr[31:0] ==? predecode_pkg::BX_PATTERN) &&
                  instr[3:0] == predecode_pkg::REG_LR;

// MOV PC, LR with no shift, no S, register operand.
assign is_mov_pc_lr = i_in.valid               &&
                      instr[34:32] == 3'd0     &&
                      instr[27:25] == 3'd0     &&
                      instr[24:21] == predecode_pkg::MOV_OPCODE &&
                      !instr[20]               &&
                      instr[19:16] == 4'd0     &&
                      instr[15:12] == predecode_pkg::REG_PC &&
                      instr[11:4]  == 8'd0     &&
                      instr[3:0]   == predecode_pkg::REG_LR;

assign is_return = is_bx_lr || is_mov_pc_lr;

// Taken if state says so or it always executes.
assign predict_taken = (is_branch || is_return) && (i_in.taken[1] || cond_al);

////////////////////////////////////////////////////////////////////////////
// Targets.
////////////////////////////////////////////////////////////////////////////

// Sign-extended 24 bit word or halfword offset.
assign offset        = {{8{instr[23]}}, instr[23:0]};
assign branch_target = i_in.pc_plus_8 + (instr[34] ? (offset << 1) : (offset << 2));
assign target        = is_return ? ras_top : branch_target;

// Return address of a call.
assign link_addr = i_in.pc + (i_thumb ? predecode_pkg::LINK_STEP_THUMB
                                      : predecode_pkg::LINK_STEP_ARM);

////////////////////////////////////////////////////////////////////////////
// Redirect and prediction code.
////////////////////////////////////////////////////////////////////////////

// Nothing leaves the stage unless it advances.
assign redirect        = predict_taken && i_advance;
assign o_redirect.clear = redirect;
assign o_redirect.pc    = redirect ? target : '0;

always_comb
begin
        if ( is_branch || is_return )
        begin
                // Not-taken keeps the incoming state.
                if ( predict_taken && cond_al )
                        o_taken = predecode_pkg::TAKEN_ST;
                else
                        o_taken = i_in.taken;
        end
        else
        begin
                o_taken = predecode_pkg::TAKEN_SNT;
        end
end

assign push = redirect && is_branch && instr[24];
assign pop  = redirect && is_return;

// Predicted PC for later checking in the ALU.
always_ff @(posedge i_clk)
begin
        if ( i_reset )
                o_ppc_ff <= '0;
        else if ( redirect )
                o_ppc_ff <= target;
end

////////////////////////////////////////////////////////////////////////////
// Return stack.
////////////////////////////////////////////////////////////////////////////

return_stack return_stack_inst
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_push         (push),
        .i_pop          (pop),
        .i_push_addr    (link_addr),
        .o_top          (ras_top)
);

endmodule

// File: verilog/predecode_stage_reg.sv
////////////////////////////////////////////////////////////////////////////
// Pre-decode pipeline register.
// Resolves the stall and clear levels by priority and holds the
// instruction bundle handed to decode.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module predecode_stage_reg
(
        // Clock and reset.
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Stall and clear levels.
        input  predecode_pkg::pipe_ctrl_t       i_ctrl,

        // Bundle from fetch.
        input  predecode_pkg::predecode_in_t    i_in,

        // Updated prediction from the predictor.
        input  predecode_pkg::taken_t           i_taken,

        // Registered bundle toward decode.
        output predecode_pkg::predecode_out_t   o_out,

        // No flush and no hold this cycle.
        output logic                            o_advance
);

logic flush;
logic hold;

////////////////////////////////////////////////////////////////////////////
// Control priority.
////////////////////////////////////////////////////////////////////////////

// Writeback clear beats everything.
// Then data stall, ALU clear, shifter stall, issue stall.
always_comb
begin
        flush = 1'b0;
        hold  = 1'b0;

        if ( i_ctrl.clear_from_writeback )
                flush = 1'b1;
        else if ( i_ctrl.data_stall )
                hold  = 1'b1;
        else if ( i_ctrl.clear_from_alu )
                flush = 1'b1;
        else if ( i_ctrl.stall_from_shifter || i_ctrl.stall_from_issue )
                hold  = 1'b1;
end

assign o_advance = !flush && !hold;

////////////////////////////////////////////////////////////////////////////
// Bundle register.
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if ( i_reset || flush )
        begin
                // Kill the slot; PCs and instruction are left as is.
                o_out.valid <= 1'b0;
                o_out.taken <= predecode_pkg::TAKEN_SNT;
                o_out.und   <= 1'b0;
                o_out.irq   <= 1'b0;
                o_out.fiq   <= 1'b0;
                o_out.abt   <= 1'b0;
        end
        else if ( o_advance )
        begin
                o_out       <= i_in;
                o_out.taken <= i_taken;
                // Undefined only counts on a real instruction.
                o_out.und   <= i_in.und && i_in.valid;
        end
        // Hold keeps everything.
end

endmodule

// File: verilog/predecode_top.sv
////////////////////////////////////////////////////////////////////////////
// Pre-decode stage top.
// Stage register toward decode plus the static branch predictor,
// which redirects fetch and tracks calls on a return stack.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module predecode_top
(
        // Clock and reset.
        input  logic                        i_clk,
        input  logic                        i_reset,

        // Pipeline stall and clear levels.
        input  predecode_pkg::pipe_ctrl_t   i_ctrl,

        // Bundle from fetch.
        input  predecode_pkg::predecode_in_t i_in,

        // CPU in Thumb state.
        input  logic                        i_thumb,

        // Bundle toward decode.
        output predecode_pkg::predecode_out_t o_out,

        // Predicted PC of the last taken branch.
        output predecode_pkg::addr_t        o_ppc_ff,

        // Fetch redirect.
        output predecode_pkg::redirect_t    o_redirect
);

// Stage advances this cycle.
logic                   advance;

// Prediction code from the predictor.
predecode_pkg::taken_t  taken;

////////////////////////////////////////////////////////////////////////////
// Stage register.
////////////////////////////////////////////////////////////////////////////

predecode_stage_reg predecode_stage_reg_inst
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_ctrl         (i_ctrl),
        .i_in           (i_in),
        .i_taken        (taken),
        .o_out          (o_out),
        .o_advance      (advance)
);

////////////////////////////////////////////////////////////////////////////
// Branch predictor.
////////////////////////////////////////////////////////////////////////////

// Sees the raw fetch bundle; commits only on advance.
branch_predict branch_predict_inst
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_in           (i_in),
        .i_thumb        (i_thumb),
        .i_advance      (advance),
        .o_redirect     (o_redirect),
        .o_taken        (taken),
        .o_ppc_ff       (o_ppc_ff)
);

endmodule

// File: bench/predecode_assertions.sv
////////////////////////////////////////////////////////////////////////////
// Pre-decode protocol assertions.
// Reset state, redirect qualification and data stall hold.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module predecode_assertions
(
        input logic                             i_clk,
        input logic                             i_reset,
        input predecode_pkg::pipe_ctrl_t        i_ctrl,
        input predecode_pkg::predecode_in_t     i_in,
        input predecode_pkg::predecode_out_t    i_out,
        input predecode_pkg::addr_t             i_ppc_ff,
        input predecode_pkg::redirect_t         i_redirect
);

// Slot is empty right after reset.
valid_low_after_reset: assert property (@(posedge i_clk) i_reset |=> !i_out.valid)
        else $error("o_out.valid high in the cycle after reset");

// Only a real instruction may redirect fetch.
redirect_needs_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        i_redirect.clear |-> i_in.valid)
        else $error("redirect raised without a valid input");

// Data stall freezes the bundle and the predicted PC.
data_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_ctrl.data_stall && !i_ctrl.clear_from_writeback) |=>
        ($stable(i_out) && $stable(i_ppc_ff)))
        else $error("o_out or o_ppc_ff changed under data stall");

endmodule

bind predecode_top predecode_assertions predecode_assertions_inst
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_ctrl         (i_ctrl),
        .i_in           (i_in),
        .i_out          (o_out),
        .i_ppc_ff       (o_ppc_ff),
        .i_redirect     (o_redirect)
);

// File: bench/predecode_tb.sv
////////////////////////////////////////////////////////////////////////////
// Pre-decode stage testbench.
// Directed tests against a bench model of priority, prediction and stack.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module predecode_tb;

localparam int CLK_PERIOD      = 100;
localparam int RAND_ITER       = 48;
// Reset, directed steps and the final drain.
localparam int DIRECTED_CYCLES = 32;
localparam int TEST_CYCLES     = DIRECTED_CYCLES + RAND_ITER;
localparam int MARGIN_CYCLES   = 50;

// Plain ADD, BX LR and MOV PC, LR encodings.
localparam predecode_pkg::instr_t ADD_INSTR = {3'b000, 32'hE081_2003};
localparam predecode_pkg::instr_t BX_LR     = {3'b000, 32'hE12F_FF1E};
localparam predecode_pkg::instr_t MOV_PC_LR = {3'b000, 32'hE1A0_F00E};

logic                           clk;
logic                           reset;
predecode_pkg::pipe_ctrl_t      ctrl;
predecode_pkg::predecode_in_t   bundle;
logic                           thumb;
predecode_pkg::predecode_out_t  out;
predecode_pkg::addr_t           ppc;
predecode_pkg::redirect_t       redirect;

// Expected state.
predecode_pkg::predecode_out_t  exp_out;
predecode_pkg::addr_t           exp_ppc;
logic                           out_loaded;
predecode_pkg::addr_t           ras_model [4];
logic [1:0]                     ras_ptr;
logic [31:0]                    lcg_state;

predecode_top predecode_top_inst
(
        .i_clk          (clk),
        .i_reset        (reset),
        .i_ctrl         (ctrl),
        .i_in           (bundle),
        .i_thumb        (thumb),
        .o_out          (out),
        .o_ppc_ff       (ppc),
        .o_redirect     (redirect)
);

initial
begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
end

////////////////////////////////////////////////////////////////////////////
// Helpers and compare tasks.
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
endfunction

task automatic report_failure(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
endtask

// PCs, instruction and force32 are unknown until the first load.
function automatic predecode_pkg::predecode_out_t datapath_cleared(
        predecode_pkg::predecode_out_t v);
        v.force32     = 1'b0;
        v.pc          = '0;
        v.pc_plus_8   = '0;
        v.instruction = '0;
        return v;
endfunction

task automatic check_out(string name, predecode_pkg::predecode_out_t exp,
                         predecode_pkg::predecode_out_t got);
        if ( !out_loaded )
        begin
                exp = datapath_cleared(exp);
                got = datapath_cleared(got);
        end
        if ( got !== exp )
                report_failure($sformatf("ERR %s expected %h actual %h", name, exp, got));
endtask

task automatic check_redirect(string name, predecode_pkg::redirect_t exp,
                              predecode_pkg::redirect_t got);
        if ( got !== exp )
                report_failure($sformatf("ERR %s expected %h actual %h", name, exp, got));
endtask

task automatic check_addr(string name, predecode_pkg::addr_t exp, predecode_pkg::addr_t got);
        if ( got !== exp )
                report_failure($sformatf("ERR %s expected %h actual %h", name, exp, got));
endtask

function automatic predecode_pkg::instr_t branch_instr(logic [3:0] cond, logic link,
                                                       logic half, logic [23:0] off);
        return {half, 2'b00, cond, 3'b101, link, off};
endfunction

function automatic predecode_pkg::predecode_in_t make_bundle(predecode_pkg::instr_t instr,
        predecode_pkg::addr_t pc, predecode_pkg::taken_t taken);
        predecode_pkg::predecode_in_t b;
        b             = '0;
        b.valid       = 1'b1;
        b.instruction = instr;
        b.pc          = pc;
        b.pc_plus_8   = pc + 32'd8;
        b.taken       = taken;
        return b;
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference model.
////////////////////////////////////////////////////////////////////////////

function automatic logic model_is_return(predecode_pkg::predecode_in_t in);
        predecode_pkg::instr_t i;
        i = in.instruction;
        if ( !in.valid )
                return 1'b0;
        // BX LR.
        if ( i[27:4] == 24'h12FFF1 && i[3:0] == 4'd14 )
                return 1'b1;
        // MOV PC, LR, register form, no shift.
        return i[34:32] == 3'd0 && i[27:21] == 7'b0001101 && i[15:12] == 4'd15 &&
               i[11:4] == 8'd0 && i[3:0] == 4'd14;
endfunction

function automatic predecode_pkg::addr_t model_target(predecode_pkg::predecode_in_t in);
        logic [31:0] off;
        off = {{8{in.instruction[23]}}, in.instruction[23:0]};
        return in.pc_plus_8 + (in.instruction[34] ? off * 32'd2 : off * 32'd4);
endfunction

// Works out this cycle's redirect and the state after the next edge.
task automatic predict(predecode_pkg::pipe_ctrl_t c, predecode_pkg::predecode_in_t in,
                       logic th, output predecode_pkg::redirect_t r);
        logic                   flush;
        logic                   hold;
        logic                   br;
        logic                   ret;
        logic                   taken_pred;
        predecode_pkg::taken_t  code;
        predecode_pkg::addr_t   tgt;
        flush = c.clear_from_writeback || (!c.data_stall && c.clear_from_alu);
        hold  = !c.clear_from_writeback && (c.data_stall ||
                (!c.clear_from_alu && (c.stall_from_shifter || c.stall_from_issue)));
        br    = in.valid && in.instruction[27:25] == 3'b101;
        ret   = model_is_return(in);
        taken_pred = (br || ret) && (in.taken[1] || in.instruction[31:28] == 4'hE);
        tgt   = ret ? ras_model[ras_ptr - 2'd1] : model_target(in);
        if ( !(br || ret) )
                code = 2'b00;
        else if ( taken_pred && in.instruction[31:28] == 4'hE )
                code = 2'b11;
        else
                code = in.taken;
        r = '0;
        if ( flush )
        begin
                exp_out.valid = 1'b0;
                exp_out.taken = 2'b00;
                exp_out.und   = 1'b0;
                exp_out.irq   = 1'b0;
                exp_out.fiq   = 1'b0;
                exp_out.abt   = 1'b0;
        end
        else if ( !hold )
        begin
                exp_out     = in;
                exp_out.taken = code;
                exp_out.und = in.und && in.valid;
                out_loaded  = 1'b1;
                if ( taken_pred )
                begin
                        r.clear = 1'b1;
                        r.pc    = tgt;
                        exp_ppc = tgt;
                        // Call pushes its return address, return pops.
                        if ( br && in.instruction[24] )
                        begin
                                ras_model[ras_ptr] = in.pc + (th ? 32'd2 : 32'd4);
                                ras_ptr = ras_ptr + 2'd1;
                        end
                        else if ( ret )
                                ras_ptr = ras_ptr - 2'd1;
                end
        end
endtask

// Drive one cycle, check the previous one and this one's redirect.
task automatic step(string name, predecode_pkg::pipe_ctrl_t c,
                    predecode_pkg::predecode_in_t in, logic th);
        predecode_pkg::redirect_t exp_redir;
        @(posedge clk);
        ctrl   <= c;
        bundle <= in;
        thumb  <= th;
        @(negedge clk);
        check_out(name, exp_out, out);
        check_addr(name, exp_ppc, ppc);
        predict(c, in, th, exp_redir);
        check_redirect(name, exp_redir, redirect);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests.
////////////////////////////////////////////////////////////////////////////

task automatic test_reset();
        predecode_pkg::redirect_t exp_redir;
        @(negedge clk);
        check_out("reset", exp_out, out);
        check_addr("reset", exp_ppc, ppc);
        // Idle inputs still sit on the bus.
        predict(ctrl, bundle, thumb, exp_redir);
        check_redirect("reset", exp_redir, redirect);
endtask

task automatic test_plain();
        predecode_pkg::predecode_in_t b;
        b     = make_bundle(ADD_INSTR, 32'h0000_0100, 2'b11);
        b.und = 1'b1;
        b.irq = 1'b1;
        step("plain_valid", '0, b, 1'b0);
        // Undefined dropped on an empty slot.
        b.valid = 1'b0;
        step("plain_invalid", '0, b, 1'b0);
        b     = make_bundle(ADD_INSTR, 32'h0000_0104, 2'b01);
        b.fiq = 1'b1;
        b.abt = 1'b1;
        step("plain_events", '0, b, 1'b0);
endtask

task automatic test_always_taken();
        step("b_arm", '0, make_bundle(branch_instr(4'hE, 1'b0, 1'b0, 24'h000123),
             32'h0000_1000, 2'b00), 1'b0);
        step("bl_half", '0, make_bundle(branch_instr(4'hE, 1'b1, 1'b1, 24'hFFFF80),
             32'h0000_1800, 2'b01), 1'b1);
        step("b_cond_not_taken", '0, make_bundle(branch_instr(4'h0, 1'b0, 1'b0, 24'h000040),
             32'h0000_1900, 2'b01), 1'b0);
        step("b_cond_taken", '0, make_bundle(branch_instr(4'h1, 1'b0, 1'b0, 24'h000010),
             32'h0000_1A00, 2'b10), 1'b0);
endtask

task automatic test_call_return();
        predecode_pkg::addr_t pc;
        pc = 32'h0000_2000;
        // Five calls, the last one overwrites the oldest entry.
        for ( int k = 0; k < 5; k++ )
        begin
                step("call", '0, make_bundle(branch_instr(4'hE, 1'b1, k[0], 24'h000200),
                     pc, 2'b00), k[0]);
                pc = pc + 32'h40;
        end
        for ( int k = 0; k < 4; k++ )
        begin
                step("return", '0, make_bundle(k[0] ? MOV_PC_LR : BX_LR, pc, 2'b00), 1'b0);
                pc = pc + 32'h4;
        end
endtask

task automatic test_priority();
        predecode_pkg::pipe_ctrl_t c;
        step("prio_advance", '0, make_bundle(ADD_INSTR, 32'h0000_4000, 2'b00), 1'b0);
        c = '0;
        c.data_stall = 1'b1;
        step("prio_data_stall", c, make_bundle(branch_instr(4'hE, 1'b1, 1'b0, 24'h000100),
             32'h0000_4004, 2'b00), 1'b0);
        step("prio_return", '0, make_bundle(BX_LR, 32'h0000_4008, 2'b00), 1'b0);
        c.clear_from_writeback = 1'b1;
        step("prio_wb_clear", c, make_bundle(ADD_INSTR, 32'h0000_400C, 2'b00), 1'b0);
        // Refill so the ALU clear has a valid slot to kill.
        step("prio_refill", '0, make_bundle(ADD_INSTR, 32'h0000_4010, 2'b00), 1'b0);
        c = '0;
        c.clear_from_alu = 1'b1;
        step("prio_alu_clear", c, make_bundle(branch_instr(4'hE, 1'b1, 1'b0, 24'h000100),
             32'h0000_4014, 2'b00), 1'b0);
        step("prio_reload", '0, make_bundle(ADD_INSTR, 32'h0000_4018, 2'b00), 1'b0);
        c = '0;
        c.stall_from_shifter = 1'b1;
        step("prio_shifter", c, make_bundle(ADD_INSTR, 32'h0000_401C, 2'b00), 1'b0);
        c = '0;
        c.stall_from_issue = 1'b1;
        step("prio_issue", c, make_bundle(ADD_INSTR, 32'h0000_4020, 2'b00), 1'b0);
endtask

task automatic test_random();
        logic [31:0]                    r;
        logic [31:0]                    off;
        logic [3:0]                     cond;
        predecode_pkg::predecode_in_t   b;
        for ( int n = 0; n < RAND_ITER; n++ )
        begin
                r    = lcg_next();
                off  = lcg_next();
                cond = r[31] ? 4'hE : r[30:27];
                b    = make_bundle(branch_instr(cond, r[26], r[25], off[31:8]),
                                   lcg_next() & 32'hFFFF_FFFC, r[24:23]);
                step("random", '0, b, r[22]);
        end
endtask

////////////////////////////////////////////////////////////////////////////
// Main sequence and watchdog.
////////////////////////////////////////////////////////////////////////////

initial
begin
        lcg_state  = 32'd27518;
        reset      = 1'b1;
        ctrl       = '0;
        bundle     = '0;
        thumb      = 1'b0;
        exp_out    = '0;
        exp_ppc    = '0;
        out_loaded = 1'b0;
        ras_ptr    = 2'd0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_plain();
        test_always_taken();
        test_call_return();
        test_priority();
        test_random();
        step("drain", '0, '0, 1'b0);
        $display("TEST PASS");
        $finish;
end

initial
begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        report_failure("Watchdog expired before the tests finished.");
end

endmodule

// File: list.f
verilog/predecode_pkg.sv
verilog/return_stack.sv
verilog/branch_predict.sv
verilog/predecode_stage_reg.sv
verilog/predecode_top.sv
bench/predecode_assertions.sv
bench/predecode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the pre-decode testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
        -f list.f \
        --top-module predecode_tb \
        -Mdir obj_dir -o predecode_sim

# The log decides the result, so a crashed run still gets searched.
./obj_dir/predecode_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
        exit 0
else
        exit 1
fi
